// File: rtl/dtlb_params.svh
`ifndef DTLB_PARAMS_SVH
`define DTLB_PARAMS_SVH

// Virtual page number is bits 31:12 of the address
`define DTLB_VPN_W 20

// Upper part of the page number, compared against stored tags
`define DTLB_TAG_W 16

// Lower part of the page number, selects the set
`define DTLB_SET_W 4
`define DTLB_NUM_SETS 16

// Associativity; the evict logic assumes exactly two ways
`define DTLB_WAYS 2

// Spare, user, writeable, present
`define DTLB_FLAGS_W 4

// Flags reported for every access while paging is disabled
// Present and writeable, not user accessible
`define DTLB_FLAGS_PAGING_OFF 4'b0011

`endif

// File: rtl/dtlb_pkg.sv
`default_nettype none

`include "dtlb_params.svh"

package dtlb_pkg;

  // Virtual or physical page number
  typedef logic [`DTLB_VPN_W-1:0] page_num_t;

  // Page number as seen by the TLB arrays
  typedef struct packed {
    logic [`DTLB_TAG_W-1:0] tag;
    logic [`DTLB_SET_W-1:0] set;
  } vaddr_t;

  // Page table entry flag nibble, bit 0 is present
  typedef struct packed {
    logic spare;
    logic user;
    logic writeable;
    logic present;
  } pte_flags_t;

  // Data word of one way
  typedef struct packed {
    pte_flags_t flags;
    page_num_t  ppn;
  } tlb_entry_t;

  // Translation request from the CPU
  typedef struct packed {
    page_num_t vpn;
    logic      is_write;
    logic      re;
  } tlb_req_t;

  // Walker response, valid in the tlb2ptw_ready cycle
  typedef struct packed {
    page_num_t  ppn;
    pte_flags_t pagetab_flags;
    pte_flags_t pagedir_flags;
  } ptw_rsp_t;

  // Lookup FSM states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COMPARING,
    ST_LOOKUP
  } lookup_state_t;

endpackage

`default_nettype wire

// File: rtl/dtlb_mode_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dtlb_mode_regs import dtlb_pkg::*; (
  input  wire logic     clkrst_mem_clk,
  input  wire logic     clkrst_mem_rst_n,
  // Live CPU side inputs
  input  wire tlb_req_t dtlb_req,
  input  wire logic     paging_on,
  input  wire logic     user_mode,
  input  wire logic     dtlb_clear,
  // Strobes from the lookup FSM
  input  wire logic     latch_req,
  input  wire logic     fsm_idle,
  // Latched view of the request in flight
  output tlb_req_t      req_q,
  output logic          paging_on_q,
  output logic          user_mode_q,
  output logic          clear_now
);

  // Clear seen while the FSM was busy
  logic clear_pend_q;

  // A clear, fresh or held over, is applied only on an idle edge
  assign clear_now = (dtlb_clear || clear_pend_q) && fsm_idle;

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      // re low after reset keeps the page fault output quiet
      req_q        <= '0;
      paging_on_q  <= 1'b0;
      user_mode_q  <= 1'b0;
      clear_pend_q <= 1'b0;
    end else begin
      // latch_req marks every accepted request
      // This includes paging-off requests, which never leave ST_IDLE
      if (latch_req) begin
        req_q       <= dtlb_req;
        paging_on_q <= paging_on;
        user_mode_q <= user_mode;
      end

      // Pending clear is dropped once it has been applied
      if (clear_now) begin
        clear_pend_q <= 1'b0;
      end else if (dtlb_clear) begin
        clear_pend_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/dtlb_entry_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtlb_params.svh"

module dtlb_entry_ram import dtlb_pkg::*; (
  input  wire logic                       clkrst_mem_clk,
  input  wire logic                       clkrst_mem_rst_n,
  // Read side, live or latched set from the FSM
  input  wire logic [`DTLB_SET_W-1:0]     rd_set,
  input  wire logic [`DTLB_TAG_W-1:0]     rd_tag,
  // Refill side
  input  wire logic [`DTLB_SET_W-1:0]     wr_set,
  input  wire logic [`DTLB_TAG_W-1:0]     wr_tag,
  input  wire logic [`DTLB_WAYS-1:0]      way_we,
  input  wire tlb_entry_t                 wr_entry,
  // Bulk invalidate
  input  wire logic                       clear_now,
  output logic [`DTLB_WAYS-1:0]           hit_way,
  output tlb_entry_t [`DTLB_WAYS-1:0]     q_entry
);

  // Per way valid bits, one per set
  logic [`DTLB_NUM_SETS-1:0] valid_q [`DTLB_WAYS];

  // Tag and data arrays
  logic [`DTLB_TAG_W-1:0]    tag_mem  [`DTLB_WAYS][`DTLB_NUM_SETS];
  tlb_entry_t                data_mem [`DTLB_WAYS][`DTLB_NUM_SETS];

  // Combinational tag compare on the read set
  // A clear in the same cycle counts as happening before the lookup
  always_comb begin
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      hit_way[w] = valid_q[w][rd_set]
                   && (tag_mem[w][rd_set] == rd_tag)
                   && !clear_now;
    end
  end

  // Valid bits, clear wins over a refill
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else if (clear_now) begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
        if (way_we[w]) begin
          valid_q[w][wr_set] <= 1'b1;
        end
      end
    end
  end

  // Tags, data and the registered data read
  always_ff @(posedge clkrst_mem_clk) begin
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (way_we[w]) begin
        tag_mem[w][wr_set]  <= wr_tag;
        data_mem[w][wr_set] <= wr_entry;
      end
      // Write-first, so the refilled word shows up right after the refill edge
      if (way_we[w] && (wr_set == rd_set)) begin
        q_entry[w] <= wr_entry;
      end else begin
        q_entry[w] <= data_mem[w][rd_set];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/dtlb_lookup_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtlb_params.svh"

module dtlb_lookup_ctrl import dtlb_pkg::*; (
  input  wire logic                   clkrst_mem_clk,
  input  wire logic                   clkrst_mem_rst_n,
  input  wire tlb_req_t               dtlb_req,
  input  wire tlb_req_t               req_q,
  input  wire logic                   paging_on,
  input  wire logic [`DTLB_WAYS-1:0]  hit_way,
  input  wire logic                   tlb2ptw_ready,
  input  wire ptw_rsp_t               tlb2ptw_rsp,
  output logic                        latch_req,
  output logic                        fsm_idle,
  output logic [`DTLB_SET_W-1:0]      rd_set,
  output logic [`DTLB_TAG_W-1:0]      rd_tag,
  output logic [`DTLB_WAYS-1:0]       way_we,
  output tlb_entry_t                  wr_entry,
  output logic                        sel_way,
  output page_num_t                   tlb2ptw_addr,
  output logic                        tlb2ptw_re,
  output logic                        dtlb_ready
);

  lookup_state_t              state_q;
  lookup_state_t              state_d;

  // Live and latched page numbers split into tag and set
  vaddr_t                     live_va;
  vaddr_t                     req_va;

  // Registered compare result of the accepted request
  logic                       hit_q;

  // One evict bit per set, names the way replaced on the next refill
  logic [`DTLB_NUM_SETS-1:0]  evict_q;
  logic                       evict_cur;
  logic                       refill;

  assign live_va   = dtlb_req.vpn;
  assign req_va    = req_q.vpn;
  assign evict_cur = evict_q[req_va.set];

  assign fsm_idle   = (state_q == ST_IDLE);
  // Results of a hit are valid during ST_COMPARING already
  assign dtlb_ready = fsm_idle || ((state_q == ST_COMPARING) && hit_q);

  // Any accepted request, paging on or off
  assign latch_req = dtlb_ready && dtlb_req.re;

  // Live set only on an accept, otherwise hold the latched set
  // Keeps the read data stable while idle
  assign rd_set = latch_req ? live_va.set : req_va.set;
  assign rd_tag = latch_req ? live_va.tag : req_va.tag;

  // Refill happens on the walker ready edge
  assign refill = (state_q == ST_LOOKUP) && tlb2ptw_ready;

  always_comb begin
    way_we = '0;
    if (refill) begin
      way_we[evict_cur] = 1'b1;
    end
  end

  // Stored flags are the AND of directory and table flags
  assign wr_entry.flags = tlb2ptw_rsp.pagedir_flags & tlb2ptw_rsp.pagetab_flags;
  assign wr_entry.ppn   = tlb2ptw_rsp.ppn;

  // req_q only moves on an accept, so the address holds through the walk
  assign tlb2ptw_addr = req_q.vpn;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // Paging-off requests are answered from ST_IDLE
        if (latch_req && paging_on) begin
          state_d = ST_COMPARING;
        end
      end
      ST_COMPARING: begin
        if (!hit_q) begin
          state_d = ST_LOOKUP;
        end else if (latch_req && paging_on) begin
          // Back-to-back hit, next compare already running
          state_d = ST_COMPARING;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_LOOKUP: begin
        // Walker stall just stretches this state
        if (tlb2ptw_ready) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      state_q    <= ST_IDLE;
      hit_q      <= 1'b0;
      sel_way    <= 1'b0;
      tlb2ptw_re <= 1'b0;
      evict_q    <= '0;
    end else begin
      state_q <= state_d;

      // Single-cycle walk request in the first ST_LOOKUP cycle
      tlb2ptw_re <= (state_q == ST_COMPARING) && !hit_q;

      // Capture the compare of the request being accepted
      if (latch_req) begin
        hit_q   <= |hit_way;
        sel_way <= hit_way[1];
      end

      // Hit, next eviction goes to the other way
      if ((state_q == ST_COMPARING) && hit_q) begin
        evict_q[req_va.set] <= ~sel_way;
      end

      // Refill, output mux follows the refilled way
      if (refill) begin
        evict_q[req_va.set] <= ~evict_cur;
        sel_way             <= evict_cur;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/dtlb_fault_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtlb_params.svh"

module dtlb_fault_check import dtlb_pkg::*; (
  input  wire tlb_entry_t [`DTLB_WAYS-1:0] q_entry,
  input  wire logic                        sel_way,
  input  wire tlb_req_t                    req_q,
  input  wire logic                        paging_on_q,
  input  wire logic                        user_mode_q,
  output page_num_t                        dtlb_phys_addr,
  output pte_flags_t                       dtlb_flags,
  output logic                             dtlb_pf
);

  tlb_entry_t hit_entry;

  // Entry of the way picked by the FSM
  assign hit_entry = q_entry[sel_way];

  // Translated page, or identity map with fixed flags
  always_comb begin
    if (paging_on_q) begin
      dtlb_phys_addr = hit_entry.ppn;
      dtlb_flags     = hit_entry.flags;
    end else begin
      dtlb_phys_addr = req_q.vpn;
      dtlb_flags     = pte_flags_t'(`DTLB_FLAGS_PAGING_OFF);
    end
  end

  // Fault on missing page, kernel page from user mode, or write to read-only
  assign dtlb_pf = req_q.re
                   && (!dtlb_flags.present
                       || (user_mode_q && !dtlb_flags.user)
                       || (req_q.is_write && !dtlb_flags.writeable));

endmodule

`default_nettype wire

// File: rtl/dtlb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtlb_params.svh"

module dtlb_top import dtlb_pkg::*; (
  input  wire logic     clkrst_mem_clk,
  input  wire logic     clkrst_mem_rst_n,
  // CPU side
  input  wire tlb_req_t dtlb_req,
  input  wire logic     dtlb_clear,
  input  wire logic     paging_on,
  input  wire logic     user_mode,
  output page_num_t     dtlb_phys_addr,
  output pte_flags_t    dtlb_flags,
  output logic          dtlb_pf,
  output logic          dtlb_ready,
  // Walker side
  input  wire ptw_rsp_t tlb2ptw_rsp,
  input  wire logic     tlb2ptw_ready,
  output page_num_t     tlb2ptw_addr,
  output logic          tlb2ptw_re
);

  tlb_req_t                        req_q;
  vaddr_t                          req_va;
  logic                            paging_on_q;
  logic                            user_mode_q;
  logic                            clear_now;
  logic                            latch_req;
  logic                            fsm_idle;
  logic [`DTLB_SET_W-1:0]          rd_set;
  logic [`DTLB_TAG_W-1:0]          rd_tag;
  logic [`DTLB_WAYS-1:0]           way_we;
  tlb_entry_t                      wr_entry;
  logic                            sel_way;
  logic [`DTLB_WAYS-1:0]           hit_way;
  tlb_entry_t [`DTLB_WAYS-1:0]     q_entry;

  // Refills always target the latched page
  assign req_va = req_q.vpn;

  dtlb_mode_regs i_dtlb_mode_regs (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .dtlb_req         (dtlb_req),
    .paging_on        (paging_on),
    .user_mode        (user_mode),
    .dtlb_clear       (dtlb_clear),
    .latch_req        (latch_req),
    .fsm_idle         (fsm_idle),
    .req_q            (req_q),
    .paging_on_q      (paging_on_q),
    .user_mode_q      (user_mode_q),
    .clear_now        (clear_now)
  );

  dtlb_entry_ram i_dtlb_entry_ram (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .rd_set           (rd_set),
    .rd_tag           (rd_tag),
    .wr_set           (req_va.set),
    .wr_tag           (req_va.tag),
    .way_we           (way_we),
    .wr_entry         (wr_entry),
    .clear_now        (clear_now),
    .hit_way          (hit_way),
    .q_entry          (q_entry)
  );

  dtlb_lookup_ctrl i_dtlb_lookup_ctrl (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .dtlb_req         (dtlb_req),
    .req_q            (req_q),
    .paging_on        (paging_on),
    .hit_way          (hit_way),
    .tlb2ptw_ready    (tlb2ptw_ready),
    .tlb2ptw_rsp      (tlb2ptw_rsp),
    .latch_req        (latch_req),
    .fsm_idle         (fsm_idle),
    .rd_set           (rd_set),
    .rd_tag           (rd_tag),
    .way_we           (way_we),
    .wr_entry         (wr_entry),
    .sel_way          (sel_way),
    .tlb2ptw_addr     (tlb2ptw_addr),
    .tlb2ptw_re       (tlb2ptw_re),
    .dtlb_ready       (dtlb_ready)
  );

  dtlb_fault_check i_dtlb_fault_check (
    .q_entry          (q_entry),
    .sel_way          (sel_way),
    .req_q            (req_q),
    .paging_on_q      (paging_on_q),
    .user_mode_q      (user_mode_q),
    .dtlb_phys_addr   (dtlb_phys_addr),
    .dtlb_flags       (dtlb_flags),
    .dtlb_pf          (dtlb_pf)
  );

endmodule

`default_nettype wire

// File: bench/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clkrst_mem_clk,
  output logic clkrst_mem_rst_n
);

  // 4 ns period
  initial begin
    clkrst_mem_clk = 1'b0;
    forever begin
      #2 clkrst_mem_clk = ~clkrst_mem_clk;
    end
  end

  // Reset held for 10 cycles, released on a falling edge
  initial begin
    clkrst_mem_rst_n = 1'b0;
    repeat (10) @(posedge clkrst_mem_clk);
    @(negedge clkrst_mem_clk);
    clkrst_mem_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/dtlb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dtlb_asserts import dtlb_pkg::*; (
  input wire logic      clkrst_mem_clk,
  input wire logic      clkrst_mem_rst_n,
  input wire tlb_req_t  dtlb_req,
  input wire logic      dtlb_ready,
  input wire page_num_t tlb2ptw_addr,
  input wire logic      tlb2ptw_re,
  input wire logic      tlb2ptw_ready
);

  // Walk issued and not yet answered
  logic walk_open_q;

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      walk_open_q <= 1'b0;
    end else if (tlb2ptw_ready) begin
      walk_open_q <= 1'b0;
    end else if (tlb2ptw_re) begin
      walk_open_q <= 1'b1;
    end
  end

  // Walk request is a single-cycle pulse
  re_single_cycle: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    tlb2ptw_re |=> !tlb2ptw_re)
    else $error("tlb2ptw_re high for more than one cycle");

  // Walk address holds until the walker answers
  addr_stable: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    (tlb2ptw_re || walk_open_q) && !tlb2ptw_ready |=> $stable(tlb2ptw_addr))
    else $error("tlb2ptw_addr changed before tlb2ptw_ready");

  // CPU only requests while the TLB is ready
  no_accept_busy: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    dtlb_req.re |-> dtlb_ready)
    else $error("request presented while dtlb_ready low");

  // Idle and ready right out of reset
  ready_after_reset: assert property (@(posedge clkrst_mem_clk)
    $rose(clkrst_mem_rst_n) |-> dtlb_ready && !tlb2ptw_re)
    else $error("TLB not idle after reset");

endmodule

`default_nettype wire

// File: bench/tb_dtlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dtlb_params.svh"

module tb_dtlb import dtlb_pkg::*; ();

  localparam int POOL           = 12;
  localparam int RAND_REQS      = 300;
  localparam int WALK_DELAY_MAX = 8;
  localparam int RESET_CYCLES   = 10;
  // Eviction, paging off, clear at idle, clear during a walk
  localparam int DIRECTED_OPS   = 7 + 8 + (2 * POOL + 1) + 3;
  localparam int CYCLE_LIMIT    =
    (RAND_REQS + DIRECTED_OPS) * (WALK_DELAY_MAX + 6) + RESET_CYCLES;

  logic       clkrst_mem_clk;
  logic       clkrst_mem_rst_n;
  tlb_req_t   dtlb_req;
  logic       dtlb_clear;
  logic       paging_on;
  logic       user_mode;
  page_num_t  dtlb_phys_addr;
  pte_flags_t dtlb_flags;
  logic       dtlb_pf;
  logic       dtlb_ready;
  ptw_rsp_t   tlb2ptw_rsp;
  logic       tlb2ptw_ready;
  page_num_t  tlb2ptw_addr;
  logic       tlb2ptw_re;

  // Page pool spread over three sets with four pages in each
  logic [3:0] pool_sets [3] = '{4'h2, 4'h7, 4'hd};
  page_num_t  pool_vpn  [POOL];
  page_num_t  pt_ppn    [POOL];
  logic [3:0] pt_dir    [POOL];
  logic [3:0] pt_tab    [POOL];

  // Reference TLB
  logic       m_valid [`DTLB_NUM_SETS][`DTLB_WAYS];
  page_num_t  m_vpn   [`DTLB_NUM_SETS][`DTLB_WAYS];
  logic       m_evict [`DTLB_NUM_SETS];

  int         checks      = 0;
  int         errors      = 0;
  int         checks_mark = 0;
  int         errors_mark = 0;
  int         walk_count  = 0;
  int         cycle_count = 0;
  page_num_t  walk_addr;
  string      test_name;

  tb_clkgen i_tb_clkgen (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n)
  );

  dtlb_top i_dtlb_top (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .dtlb_req         (dtlb_req),
    .dtlb_clear       (dtlb_clear),
    .paging_on        (paging_on),
    .user_mode        (user_mode),
    .dtlb_phys_addr   (dtlb_phys_addr),
    .dtlb_flags       (dtlb_flags),
    .dtlb_pf          (dtlb_pf),
    .dtlb_ready       (dtlb_ready),
    .tlb2ptw_rsp      (tlb2ptw_rsp),
    .tlb2ptw_ready    (tlb2ptw_ready),
    .tlb2ptw_addr     (tlb2ptw_addr),
    .tlb2ptw_re       (tlb2ptw_re)
  );

  bind dtlb_top dtlb_asserts i_dtlb_asserts (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .dtlb_req         (dtlb_req),
    .dtlb_ready       (dtlb_ready),
    .tlb2ptw_addr     (tlb2ptw_addr),
    .tlb2ptw_re       (tlb2ptw_re),
    .tlb2ptw_ready    (tlb2ptw_ready)
  );

  task automatic check_value(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    assert (act_val === exp_val)
    else begin
      errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name,
             checks - checks_mark, errors - errors_mark);
  endtask

  // Unique tags per set with random page and flag nibbles
  task automatic build_page_table();
    logic [11:0] tag_hi;
    for (int i = 0; i < POOL; i++) begin
      tag_hi      = 12'($urandom);
      pool_vpn[i] = {tag_hi, 4'(i), pool_sets[i % 3]};
      pt_ppn[i]   = 20'($urandom);
      pt_dir[i]   = 4'($urandom);
      pt_tab[i]   = 4'($urandom);
    end
  endtask

  function automatic int pool_index(input page_num_t vpn);
    pool_index = -1;
    for (int i = 0; i < POOL; i++) begin
      if (pool_vpn[i] == vpn) begin
        pool_index = i;
      end
    end
  endfunction

  function automatic int model_lookup(input page_num_t vpn);
    int s;
    s = vpn[`DTLB_SET_W-1:0];
    model_lookup = -1;
    for (int w = 0; w < `DTLB_WAYS; w++) begin
      if (m_valid[s][w] && (m_vpn[s][w] == vpn)) begin
        model_lookup = w;
      end
    end
  endfunction

  // Evict bits survive a clear
  task automatic model_invalidate();
    for (int s = 0; s < `DTLB_NUM_SETS; s++) begin
      for (int w = 0; w < `DTLB_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
      end
    end
  endtask

  // A hit points the evict bit at the other way and a refill fills the named way and flips it
  task automatic model_update(input page_num_t vpn, input int way);
    int s;
    int w;
    s = vpn[`DTLB_SET_W-1:0];
    if (way >= 0) begin
      m_evict[s] = (way == 0);
    end else begin
      w            = m_evict[s];
      m_valid[s][w] = 1'b1;
      m_vpn[s][w]   = vpn;
      m_evict[s]    = !m_evict[s];
    end
  endtask

  // One request issued on a falling edge
  task automatic translate(input int idx, input bit pg_on, input bit um, input bit wr,
                           input bit clear_in_walk, output int walked);
    page_num_t  vpn;
    page_num_t  exp_ppn;
    pte_flags_t exp_flags;
    bit         exp_pf;
    bit         exp_walk;
    int         way;
    int         walks_before;
    int         lat;
    vpn      = pool_vpn[idx];
    way      = model_lookup(vpn);
    exp_walk = pg_on && (way < 0);
    if (pg_on) begin
      exp_ppn   = pt_ppn[idx];
      exp_flags = pt_dir[idx] & pt_tab[idx];
    end else begin
      exp_ppn   = vpn;
      exp_flags = `DTLB_FLAGS_PAGING_OFF;
    end
    exp_pf = !exp_flags.present || (um && !exp_flags.user) || (wr && !exp_flags.writeable);
    while (!dtlb_ready) begin
      @(negedge clkrst_mem_clk);
    end
    walks_before     = walk_count;
    dtlb_req.vpn      = vpn;
    dtlb_req.is_write = wr;
    dtlb_req.re       = 1'b1;
    paging_on         = pg_on;
    user_mode         = um;
    lat               = 0;
    // Accepted on the next rising edge and then waits for ready
    do begin
      @(negedge clkrst_mem_clk);
      lat++;
      dtlb_req.re = 1'b0;
      // Clear pulse in the first walk cycle
      dtlb_clear  = clear_in_walk && tlb2ptw_re;
    end while (!dtlb_ready);
    walked = walk_count - walks_before;
    check_value("walk count", exp_walk, walked);
    if (exp_walk) begin
      check_value("walk address", vpn, walk_addr);
    end else begin
      check_value("ready latency", 1, lat);
    end
    check_value("phys page", exp_ppn, dtlb_phys_addr);
    check_value("flags", exp_flags, dtlb_flags);
    check_value("page fault", exp_pf, dtlb_pf);
    if (pg_on) begin
      model_update(vpn, way);
    end
    // A clear held during the walk lands after the refill
    if (clear_in_walk && exp_walk) begin
      model_invalidate();
    end
  endtask

  // Clear pulse with no request pending
  task automatic clear_tlb();
    while (!dtlb_ready) begin
      @(negedge clkrst_mem_clk);
    end
    dtlb_clear = 1'b1;
    @(negedge clkrst_mem_clk);
    dtlb_clear = 1'b0;
    @(negedge clkrst_mem_clk);
    model_invalidate();
  endtask

  // Walker model answering from the page table after 1 to 8 cycles
  initial begin : walker
    int idx;
    int delay;
    tlb2ptw_ready = 1'b0;
    tlb2ptw_rsp   = '0;
    forever begin
      @(negedge clkrst_mem_clk);
      if (tlb2ptw_re) begin
        walk_count++;
        walk_addr = tlb2ptw_addr;
        idx       = pool_index(tlb2ptw_addr);
        assert (idx >= 0)
        else begin
          errors++;
          $display("walker asked for page %h, which is not in the page table", tlb2ptw_addr);
        end
        delay = 1 + ($urandom % WALK_DELAY_MAX);
        repeat (delay) @(negedge clkrst_mem_clk);
        tlb2ptw_ready = 1'b1;
        if (idx >= 0) begin
          tlb2ptw_rsp.ppn           = pt_ppn[idx];
          tlb2ptw_rsp.pagetab_flags = pt_tab[idx];
          tlb2ptw_rsp.pagedir_flags = pt_dir[idx];
        end
        @(negedge clkrst_mem_clk);
        tlb2ptw_ready = 1'b0;
        tlb2ptw_rsp   = '0;
      end
    end
  end

  // Run limit
  always @(posedge clkrst_mem_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, run still busy after %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  initial begin : main
    int walked;
    int evict_seq  [6];
    int evict_walk [6];
    dtlb_req   = '0;
    dtlb_clear = 1'b0;
    paging_on  = 1'b0;
    user_mode  = 1'b0;
    void'($urandom(65));
    build_page_table();
    model_invalidate();
    for (int s = 0; s < `DTLB_NUM_SETS; s++) begin
      m_evict[s] = 1'b0;
    end
    @(posedge clkrst_mem_rst_n);
    @(negedge clkrst_mem_clk);

    // Random pages, modes and gaps where a gap of 0 gives back-to-back requests
    start_test("random_mix");
    for (int n = 0; n < RAND_REQS; n++) begin
      repeat ($urandom % 3) @(negedge clkrst_mem_clk);
      translate($urandom % POOL, ($urandom % 8) != 0, $urandom % 2, $urandom % 2, 1'b0, walked);
    end
    end_test();

    // Pages 0, 3, 6 share a set
    start_test("eviction");
    evict_seq  = '{0, 3, 0, 6, 0, 3};
    evict_walk = '{1, 1, 0, 1, 0, 1};
    clear_tlb();
    for (int k = 0; k < 6; k++) begin
      translate(evict_seq[k], 1'b1, 1'b0, 1'b0, 1'b0, walked);
      check_value("evict walk", evict_walk[k], walked);
    end
    end_test();

    start_test("paging_off");
    for (int k = 0; k < 8; k++) begin
      translate($urandom % POOL, 1'b0, $urandom % 2, $urandom % 2, 1'b0, walked);
    end
    end_test();

    start_test("clear_idle");
    for (int i = 0; i < POOL; i++) begin
      translate(i, 1'b1, 1'b0, 1'b0, 1'b0, walked);
    end
    clear_tlb();
    // Reverse order reaches first the two pages that each set still held
    for (int i = POOL - 1; i >= 0; i--) begin
      translate(i, 1'b1, 1'b0, 1'b0, 1'b0, walked);
      check_value("first access walk", 1, walked);
    end
    end_test();

    start_test("clear_during_walk");
    clear_tlb();
    translate(1, 1'b1, 1'b0, 1'b0, 1'b1, walked);
    check_value("walk with clear", 1, walked);
    translate(1, 1'b1, 1'b0, 1'b0, 1'b0, walked);
    check_value("walk after clear", 1, walked);
    end_test();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dtlb_top.f
+incdir+rtl
rtl/dtlb_pkg.sv
rtl/dtlb_mode_regs.sv
rtl/dtlb_entry_ram.sv
rtl/dtlb_lookup_ctrl.sv
rtl/dtlb_fault_check.sv
rtl/dtlb_top.sv
bench/tb_clkgen.sv
bench/dtlb_asserts.sv
bench/tb_dtlb.sv
